// File: hw/fetch_pkg.sv
// fetch unit definitions
package fetch_pkg;

    localparam int ADDR_WIDTH   = 32;   // byte address
    localparam int INSTR_WIDTH  = 32;
    localparam int INSTR_BYTES  = 4;    // sequential pc step
    localparam int OPCODE_WIDTH = 6;    // instr[31:26]
    localparam int OFFSET_WIDTH = 16;   // signed word offset, instr[15:0]

    // instruction queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QPTR_BITS   = $clog2(QUEUE_DEPTH);

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [INSTR_WIDTH-1:0]  instr_t;
    typedef logic [OPCODE_WIDTH-1:0] opcode_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [QPTR_BITS-1:0]    qptr_t;
    typedef logic [QPTR_BITS:0]      qcount_t;    // one extra bit to hold depth

    // opcodes that redirect the fetch stream
    localparam opcode_t OP_BRANCH = 6'h04;  // conditional, taken when backward
    localparam opcode_t OP_JUMP   = 6'h02;  // always taken

endpackage

// File: hw/icache_pkg.sv
// instruction cache geometry
package icache_pkg;

    localparam int BLOCK_WIDTH = 64;    // two instructions per block
    localparam int NUM_SETS    = 16;
    localparam int NUM_WAYS    = 2;     // lru is a single bit per set

    // address split: tag | index | offset
    localparam int OFFSET_BITS = 3;     // byte offset within block
    localparam int INDEX_BITS  = $clog2(NUM_SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    typedef logic [BLOCK_WIDTH-1:0] block_t;
    typedef logic [TAG_BITS-1:0]    tag_t;
    typedef logic [INDEX_BITS-1:0]  index_t;

endpackage

// File: hw/fetch_entry_if.sv
// fetch entry enqueue interface
`timescale 1ns/1ps

interface fetch_entry_if;
    import fetch_pkg::*;

    logic   valid;      // fetch has a hit
    logic   ready;      // queue has room
    instr_t instr;
    addr_t  pc;
    logic   is_branch;  // branch or jump
    logic   pred_taken;
    addr_t  target;
    logic   flush;      // recovery, empties queue

    // fetch side
    modport producer (
        output valid, instr, pc, is_branch, pred_taken, target, flush,
        input  ready
    );

    // queue side
    modport consumer (
        input  valid, instr, pc, is_branch, pred_taken, target, flush,
        output ready
    );

endinterface

// File: hw/icache.sv
// two-way instruction cache
`timescale 1ns/1ps

module icache (
    input  logic               clk,
    input  logic               rst,
    input  fetch_pkg::addr_t   addr,
    input  logic               fill_valid,
    input  icache_pkg::block_t fill_data,
    output logic               hit,
    output icache_pkg::block_t hit_block,
    output logic               req_valid,
    output fetch_pkg::addr_t   req_addr
);
    import fetch_pkg::*;
    import icache_pkg::*;

    tag_t                tag_q   [NUM_WAYS][NUM_SETS];
    block_t              data_q  [NUM_WAYS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
    logic [NUM_SETS-1:0] lru_q;     // 1 -> way 1 is next victim
    logic                pend_q;    // fill outstanding

    tag_t                lookup_tag;
    index_t              lookup_idx;
    tag_t                fill_tag;
    index_t              fill_idx;
    logic [NUM_WAYS-1:0] hit_way;
    logic                victim;
    logic                launch;

    assign lookup_tag = addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign lookup_idx = addr[OFFSET_BITS +: INDEX_BITS];

    // fill goes where the request pointed, even if the pc moved on
    assign fill_tag = req_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign fill_idx = req_addr[OFFSET_BITS +: INDEX_BITS];
    assign victim   = lru_q[fill_idx];

    // compare both ways of the set
    always_comb begin
        hit_block = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = valid_q[w][lookup_idx] && (tag_q[w][lookup_idx] == lookup_tag);
            if (hit_way[w]) begin
                hit_block = hit_block | data_q[w][lookup_idx];   // at most one way
            end
        end
    end

    assign hit = |hit_way;

    // miss with nothing in flight; a returning fill takes the cycle
    assign launch = !hit && !pend_q && !fill_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                valid_q[w] <= '0;
            end
            lru_q     <= '0;
            pend_q    <= 1'b0;
            req_valid <= 1'b0;
        end else begin
            req_valid <= launch;    // single cycle pulse
            if (hit) begin
                lru_q[lookup_idx] <= ~hit_way[1];   // other way becomes victim
            end
            if (fill_valid) begin
                valid_q[victim][fill_idx] <= 1'b1;
                lru_q[fill_idx]           <= ~victim;   // wins over a hit update
                pend_q                    <= 1'b0;
            end else if (launch) begin
                pend_q <= 1'b1;
            end
        end
    end

    // tag, data and request address
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_q[victim][fill_idx]  <= fill_tag;
            data_q[victim][fill_idx] <= fill_data;
        end
        if (launch) begin
            req_addr <= {lookup_tag, lookup_idx, OFFSET_BITS'(0)};  // block aligned
        end
    end

    // each request opens a new pending fill
    a_no_req_pending: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> $rose(pend_q));

    // fills never duplicate a block across ways
    a_one_way_hit: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit_way));

endmodule

// File: hw/next_pc_predictor.sv
// static next pc predictor
`timescale 1ns/1ps

module next_pc_predictor (
    input  fetch_pkg::instr_t instr,
    input  fetch_pkg::addr_t  pc,
    output logic              is_branch,
    output logic              pred_taken,
    output fetch_pkg::addr_t  target,
    output fetch_pkg::addr_t  next_pc
);
    import fetch_pkg::*;

    opcode_t opcode;
    offset_t offset;
    addr_t   offset_ext;
    logic    is_cond;
    logic    is_jump;

    // decode fields
    assign opcode = instr[INSTR_WIDTH-1 -: OPCODE_WIDTH];
    assign offset = instr[OFFSET_WIDTH-1:0];

    // sign extend word offset
    assign offset_ext = {{(ADDR_WIDTH-OFFSET_WIDTH){offset[OFFSET_WIDTH-1]}}, offset};

    assign is_cond   = (opcode == OP_BRANCH);
    assign is_jump   = (opcode == OP_JUMP);
    assign is_branch = is_cond || is_jump;

    // backward branches taken (loops), jumps always
    assign pred_taken = is_jump || (is_cond && offset[OFFSET_WIDTH-1]);

    // word offset to byte offset
    assign target = pc + offset_ext * addr_t'(INSTR_BYTES);

    assign next_pc = pred_taken ? target : pc + addr_t'(INSTR_BYTES);

endmodule

// File: hw/instr_queue.sv
// instruction queue
`timescale 1ns/1ps

module instr_queue (
    input  logic              clk,
    input  logic              rst,
    fetch_entry_if.consumer   enq,
    input  logic              deq_ready,
    output logic              deq_valid,
    output fetch_pkg::instr_t deq_instr,
    output fetch_pkg::addr_t  deq_pc,
    output logic              deq_is_branch,
    output logic              deq_pred_taken,
    output fetch_pkg::addr_t  deq_target
);
    import fetch_pkg::*;

    // entry storage
    instr_t                 instr_q  [QUEUE_DEPTH];
    addr_t                  pc_q     [QUEUE_DEPTH];
    addr_t                  target_q [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] is_branch_q;
    logic [QUEUE_DEPTH-1:0] pred_taken_q;

    qptr_t   wr_ptr_q;
    qptr_t   rd_ptr_q;
    qcount_t count_q;
    logic    enq_fire;
    logic    deq_fire;

    assign enq.ready = (count_q < qcount_t'(QUEUE_DEPTH));  // no bypass from dequeue
    assign deq_valid = (count_q != '0);

    assign enq_fire = enq.valid && enq.ready && !enq.flush;  // flush drops the fetch
    assign deq_fire = deq_valid && deq_ready;

    // head entry
    assign deq_instr      = instr_q[rd_ptr_q];
    assign deq_pc         = pc_q[rd_ptr_q];
    assign deq_is_branch  = is_branch_q[rd_ptr_q];
    assign deq_pred_taken = pred_taken_q[rd_ptr_q];
    assign deq_target     = target_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || enq.flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (enq_fire) wr_ptr_q <= wr_ptr_q + qptr_t'(1);   // wraps at depth
            if (deq_fire) rd_ptr_q <= rd_ptr_q + qptr_t'(1);
            case ({enq_fire, deq_fire})
                2'b10:   count_q <= count_q + qcount_t'(1);
                2'b01:   count_q <= count_q - qcount_t'(1);
                default: count_q <= count_q;   // both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq_fire) begin
            instr_q[wr_ptr_q]      <= enq.instr;
            pc_q[wr_ptr_q]         <= enq.pc;
            is_branch_q[wr_ptr_q]  <= enq.is_branch;
            pred_taken_q[wr_ptr_q] <= enq.pred_taken;
            target_q[wr_ptr_q]     <= enq.target;
        end
    end

    // a write never lands on an unread head entry
    a_no_enq_full: assert property (@(posedge clk) disable iff (rst)
        enq_fire |-> (count_q == '0) || (wr_ptr_q != rd_ptr_q));

    a_no_deq_empty: assert property (@(posedge clk) disable iff (rst)
        deq_fire |-> (count_q != '0) && (wr_ptr_q != rd_ptr_q || count_q[QPTR_BITS]));

endmodule

// File: hw/ifu.sv
// instruction fetch unit
`timescale 1ns/1ps

module ifu (
    input  logic               clk,
    input  logic               rst,
    input  fetch_pkg::addr_t   recovery_pc,
    input  logic               recovery_pc_valid,
    output logic               mem_req_valid,
    output fetch_pkg::addr_t   mem_req_addr,
    input  logic               mem_resp_valid,
    input  icache_pkg::block_t mem_resp_data,
    input  logic               dispatch_ready,
    output logic               instr_valid,
    output fetch_pkg::instr_t  instr_data,
    output fetch_pkg::addr_t   instr_pc,
    output logic               instr_is_branch,
    output logic               instr_pred_taken,
    output fetch_pkg::addr_t   instr_target
);
    import fetch_pkg::*;
    import icache_pkg::*;

    addr_t  pc_q;
    addr_t  pc_d;
    addr_t  pred_next_pc;
    addr_t  br_target;
    instr_t fetch_instr;
    block_t hit_block;
    logic   hit;
    logic   stall;
    logic   br_is;
    logic   br_taken;

    fetch_entry_if fe ();

    icache i_icache (
        .clk        (clk),
        .rst        (rst),
        .addr       (pc_q),
        .fill_valid (mem_resp_valid),
        .fill_data  (mem_resp_data),
        .hit        (hit),
        .hit_block  (hit_block),
        .req_valid  (mem_req_valid),
        .req_addr   (mem_req_addr)
    );

    // pc bit 2 picks the word, lower address in the low half
    assign fetch_instr = pc_q[OFFSET_BITS-1] ? hit_block[BLOCK_WIDTH-1 -: INSTR_WIDTH]
                                             : hit_block[INSTR_WIDTH-1:0];

    next_pc_predictor i_pred (
        .instr      (fetch_instr),
        .pc         (pc_q),
        .is_branch  (br_is),
        .pred_taken (br_taken),
        .target     (br_target),
        .next_pc    (pred_next_pc)
    );

    // producer side of the entry
    assign fe.valid      = hit;
    assign fe.instr      = fetch_instr;
    assign fe.pc         = pc_q;
    assign fe.is_branch  = br_is;
    assign fe.pred_taken = br_taken;
    assign fe.target     = br_target;
    assign fe.flush      = recovery_pc_valid;   // queue drops this fetch too

    instr_queue i_queue (
        .clk            (clk),
        .rst            (rst),
        .enq            (fe.consumer),
        .deq_ready      (dispatch_ready),
        .deq_valid      (instr_valid),
        .deq_instr      (instr_data),
        .deq_pc         (instr_pc),
        .deq_is_branch  (instr_is_branch),
        .deq_pred_taken (instr_pred_taken),
        .deq_target     (instr_target)
    );

    assign stall = !hit || !fe.ready;   // miss or full queue

    // next pc: recovery, then hold, then prediction
    always_comb begin
        if (recovery_pc_valid)
            pc_d = recovery_pc;
        else if (stall)
            pc_d = pc_q;
        else
            pc_d = pred_next_pc;
    end

    always_ff @(posedge clk) begin
        if (rst) pc_q <= '0;
        else     pc_q <= pc_d;
    end

    // recovery targets and predicted paths keep word alignment
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_q[$clog2(INSTR_BYTES)-1:0] == '0);

endmodule

// File: testbench/ifu_tb.sv
// instruction fetch unit testbench
`timescale 1ns/1ps

module ifu_tb;
    import fetch_pkg::*;
    import icache_pkg::*;

    localparam int PROG_WORDS  = 256;      // 1 KiB program
    localparam int NUM_ENTRIES = 2000;
    localparam int IDLE_LIMIT  = 300;      // cycles without an accepted entry
    localparam int MAX_CYCLES  = 200000;

    logic   clk;
    logic   rst;
    addr_t  recovery_pc;
    logic   recovery_pc_valid;
    logic   mem_req_valid;
    addr_t  mem_req_addr;
    logic   mem_resp_valid;
    block_t mem_resp_data;
    logic   dispatch_ready;
    logic   instr_valid;
    instr_t instr_data;
    addr_t  instr_pc;
    logic   instr_is_branch;
    logic   instr_pred_taken;
    addr_t  instr_target;

    instr_t      prog [PROG_WORDS];
    logic [31:0] lcg_state;
    addr_t       exp_pc;      // model pc of the next entry to leave the queue
    int          errors;
    int          accepted;
    int          requests;

    ifu i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("%s at %0t", msg, $time);
        errors++;
    endtask

    // mostly plain words, some short branches and jumps
    function automatic instr_t make_instr(input int idx);
        instr_t      ins;
        logic [31:0] r;
        int          off;
        ins = next_rand();
        r   = next_rand();
        off = int'(r[18:16]) + 1;    // 1..8 words
        if (r[19]) off = -off;
        if (idx + off < 0 || idx + off >= PROG_WORDS) off = -off;   // keep target in program
        if (r[31:28] < 4'd2) begin
            ins[31:26] = OP_BRANCH;
            ins[15:0]  = 16'(off);
        end else if (r[31:28] == 4'd2) begin
            ins[31:26] = OP_JUMP;
            ins[15:0]  = 16'(off);
        end else if (ins[31:26] == OP_BRANCH || ins[31:26] == OP_JUMP) begin
            ins[31] = 1'b1;          // plain opcode
        end
        return ins;
    endfunction

    // static prediction rule applied to the model pc
    task automatic check_entry();
        instr_t ins;
        addr_t  off_ext;
        addr_t  tgt;
        logic   is_jump;
        logic   is_cond;
        logic   taken;
        if (instr_pc !== exp_pc) begin
            report_value("instr_pc", instr_pc, exp_pc);
            exp_pc = instr_pc;       // follow the dut after a wrong pc
        end
        ins     = prog[exp_pc[9:2]];
        is_jump = (ins[31:26] == OP_JUMP);
        is_cond = (ins[31:26] == OP_BRANCH);
        taken   = is_jump || (is_cond && ins[15]);   // backward branch
        off_ext = {{16{ins[15]}}, ins[15:0]};
        tgt     = exp_pc + (off_ext << 2);
        if (instr_data !== ins) report_value("instr_data", instr_data, ins);
        if (instr_is_branch !== (is_jump || is_cond))
            report_value("instr_is_branch", 32'(instr_is_branch), 32'(is_jump || is_cond));
        if (instr_pred_taken !== taken)
            report_value("instr_pred_taken", 32'(instr_pred_taken), 32'(taken));
        if (instr_target !== tgt) report_value("instr_target", instr_target, tgt);
        exp_pc = taken ? tgt : exp_pc + 32'd4;
    endtask

    initial begin
        logic [31:0] r;
        int          idle;
        int          cycles;
        int          resp_delay;   // cycles until the memory answers, 0 when idle
        int          hold_cnt;     // remaining long back-pressure stretch
        logic        was_pending;
        logic        seen_req;
        logic        held;
        logic        timed_out;
        addr_t       held_pc;
        addr_t       resp_addr;
        rst               = 1'b1;
        recovery_pc       = '0;
        recovery_pc_valid = 1'b0;
        mem_resp_valid    = 1'b0;
        mem_resp_data     = '0;
        dispatch_ready    = 1'b0;
        lcg_state  = 32'hda2e;
        errors     = 0;
        accepted   = 0;
        requests   = 0;
        idle       = 0;
        cycles     = 0;
        resp_delay = 0;
        hold_cnt   = 0;
        seen_req   = 1'b0;
        held       = 1'b0;
        timed_out  = 1'b0;
        held_pc    = '0;
        resp_addr  = '0;
        exp_pc     = '0;
        for (int i = 0; i < PROG_WORDS; i++) prog[i] = make_instr(i);
        prog[PROG_WORDS-1] = {OP_JUMP, 10'h000, 16'(-(PROG_WORDS-1))};   // wrap to 0

        repeat (5) @(negedge clk);
        rst = 1'b0;
        if (instr_valid !== 1'b0) report_value("instr_valid", 32'(instr_valid), 32'h0);
        if (mem_req_valid !== 1'b0) report_value("mem_req_valid", 32'(mem_req_valid), 32'h0);

        while (accepted < NUM_ENTRIES && !timed_out) begin
            @(negedge clk);
            cycles++;
            // memory model, one outstanding block
            was_pending    = (resp_delay > 0);
            mem_resp_valid = 1'b0;
            if (resp_delay > 0) begin
                resp_delay--;
                if (resp_delay == 0) begin
                    mem_resp_valid = 1'b1;
                    mem_resp_data  = {prog[{resp_addr[9:3], 1'b1}], prog[{resp_addr[9:3], 1'b0}]};
                end
            end
            if (mem_req_valid) begin
                requests++;
                if (was_pending) report_failure("second memory request before the response");
                if (!seen_req && mem_req_addr !== 32'h0)
                    report_value("mem_req_addr", mem_req_addr, 32'h0);
                if (mem_req_addr[2:0] !== 3'b000 || mem_req_addr >= 32'd1024)
                    report_failure($sformatf("memory request to bad address %h", mem_req_addr));
                seen_req   = 1'b1;
                resp_addr  = mem_req_addr;
                r          = next_rand();
                resp_delay = 1 + int'(r[23:16] % 8'd6);   // 1..6 cycles
            end
            // dispatch back-pressure
            r = next_rand();
            if (hold_cnt > 0) begin
                hold_cnt--;
                dispatch_ready = 1'b0;
            end else if (r[31:26] == 6'h00) begin
                hold_cnt       = 10 + int'(r[15:0] % 16'd32);   // long stall
                dispatch_ready = 1'b0;
            end else begin
                dispatch_ready = (r[25:24] != 2'b00);
            end
            // occasional redirect, aligned and inside the program
            r = next_rand();
            recovery_pc_valid = seen_req && (r[31:25] == 7'h00);
            recovery_pc       = {22'h0, r[15:8], 2'b00};
            if (held && (instr_valid !== 1'b1 || instr_pc !== held_pc))
                report_failure("held entry dropped or changed under back-pressure");
            if (instr_valid && dispatch_ready) begin
                check_entry();        // dequeued at the next edge
                accepted++;
                idle = 0;
            end else begin
                idle++;
            end
            held    = instr_valid && !dispatch_ready && !recovery_pc_valid;
            held_pc = instr_pc;
            if (recovery_pc_valid) exp_pc = recovery_pc;   // flush, restart there
            if (idle > IDLE_LIMIT || cycles > MAX_CYCLES) begin
                report_failure($sformatf("timeout after %0d entries, no entry for %0d cycles",
                                         accepted, idle));
                timed_out = 1'b1;
            end
        end

        $display("errors %0d, entries %0d, memory requests %0d, cycles %0d",
                 errors, accepted, requests, cycles);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: ifu.f
hw/fetch_pkg.sv
hw/icache_pkg.sv
hw/fetch_entry_if.sv
hw/icache.sv
hw/next_pc_predictor.sv
hw/instr_queue.sv
hw/ifu.sv
testbench/ifu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the fetch unit testbench with verilator, run it, then scan the log
verilator --binary --timing --assert -sv --top-module ifu_tb -f ifu.f -o ifu_sim \
    > build.log 2>&1 &&
    ./obj_dir/ifu_sim > sim.log 2>&1 ||
    { echo "build or simulation aborted, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "TESTS FAILED" sim.log && exit 1 || exit 0
